//--- src/axi_cmp_pkg.sv
package axi_cmp_pkg;

    // ------------------------------
    // Field widths
    // ------------------------------

    // Upper bound for the ID field of a beat
    localparam int unsigned MaxIdWidth = 4;

    localparam int unsigned AddrWidth  = 32;
    localparam int unsigned DataWidth  = 32;
    localparam int unsigned LenWidth   = 8;
    localparam int unsigned RespWidth  = 2;
    localparam int unsigned CountWidth = 16;

    typedef logic [MaxIdWidth-1:0] id_t;
    typedef logic [AddrWidth-1:0]  addr_t;
    typedef logic [DataWidth-1:0]  data_t;
    typedef logic [LenWidth-1:0]   len_t;
    typedef logic [RespWidth-1:0]  resp_t;

    // Saturating mismatch counter
    typedef logic [CountWidth-1:0] count_t;

    // ------------------------------
    // Beat formats
    // ------------------------------

    // Read address beat, 44 bits
    typedef struct packed {
        id_t   id;
        addr_t addr;
        len_t  len;
    } ar_beat_t;

    // Read data beat, 39 bits
    typedef struct packed {
        id_t   id;
        data_t data;
        resp_t resp;
        logic  last;
    } r_beat_t;

endpackage

//--- src/beat_fifo.sv
`timescale 1ns/1ps

module beat_fifo #(
    parameter int unsigned Depth  = 4,
    parameter type         beat_t = logic
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  push_i,
    input  beat_t data_i,
    output logic  full_o,
    input  logic  pop_i,
    output beat_t data_o,
    output logic  valid_o
);

    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);

    beat_t           mem_q [Depth];
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            do_push;
    logic            do_pop;

    // Pointer wrap at the end of the buffer
    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CntW'(Depth));
    assign valid_o = (count_q != '0);
    assign data_o  = mem_q[rd_ptr_q];

    // Push when full and pop when empty are dropped
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & valid_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            // Occupancy holds when both happen together
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- src/dual_bus_tap.sv
`timescale 1ns/1ps

module dual_bus_tap
    import axi_cmp_pkg::*;
#(
    parameter int unsigned IdWidth = 2
) (
    input  ar_beat_t                a_ar_i,
    input  logic                    a_ar_valid_i,
    output logic                    a_ar_ready_o,
    output logic                    a_ar_valid_o,
    input  logic                    a_ar_ready_i,
    input  r_beat_t                 a_r_i,
    input  logic                    a_r_valid_i,
    output logic                    a_r_ready_o,
    output logic                    a_r_valid_o,
    input  logic                    a_r_ready_i,
    input  ar_beat_t                b_ar_i,
    input  logic                    b_ar_valid_i,
    output logic                    b_ar_ready_o,
    output logic                    b_ar_valid_o,
    input  logic                    b_ar_ready_i,
    input  r_beat_t                 b_r_i,
    input  logic                    b_r_valid_i,
    output logic                    b_r_ready_o,
    output logic                    b_r_valid_o,
    input  logic                    b_r_ready_i,
    input  logic [2**IdWidth-1:0]   ar_space_a_i,
    input  logic [2**IdWidth-1:0]   ar_space_b_i,
    input  logic [2**IdWidth-1:0]   r_space_a_i,
    input  logic [2**IdWidth-1:0]   r_space_b_i,
    output logic [2**IdWidth-1:0]   ar_push_a_o,
    output logic [2**IdWidth-1:0]   ar_push_b_o,
    output logic [2**IdWidth-1:0]   r_push_a_o,
    output logic [2**IdWidth-1:0]   r_push_b_o
);

    localparam int unsigned NumLanes = 2**IdWidth;
    localparam int unsigned NumCh    = 4;

    // ------------------------------
    // Channel packing
    // ------------------------------

    // Index 0 is A AR, 1 is B AR, 2 is A R, 3 is B R
    logic [NumCh-1:0][IdWidth-1:0]  sel;
    logic [NumCh-1:0][NumLanes-1:0] space;
    logic [NumCh-1:0][NumLanes-1:0] push;
    logic [NumCh-1:0]               valid_in;
    logic [NumCh-1:0]               ready_dn;
    logic [NumCh-1:0]               has_space;
    logic [NumCh-1:0]               accept;

    assign sel      = {b_r_i.id[IdWidth-1:0], a_r_i.id[IdWidth-1:0],
                       b_ar_i.id[IdWidth-1:0], a_ar_i.id[IdWidth-1:0]};
    assign space    = {r_space_b_i, r_space_a_i, ar_space_b_i, ar_space_a_i};
    assign valid_in = {b_r_valid_i, a_r_valid_i, b_ar_valid_i, a_ar_valid_i};
    assign ready_dn = {b_r_ready_i, a_r_ready_i, b_ar_ready_i, a_ar_ready_i};

    // ------------------------------
    // Gating and steering
    // ------------------------------
    for (genvar c = 0; c < NumCh; c++) begin : gen_chan
        // Room in the lane this beat maps to
        assign has_space[c] = space[c][sel[c]];
        assign accept[c]    = valid_in[c] & ready_dn[c] & has_space[c];

        for (genvar l = 0; l < NumLanes; l++) begin : gen_push
            assign push[c][l] = accept[c] & (sel[c] == IdWidth'(l));
        end
    end

    assign a_ar_valid_o = valid_in[0] & has_space[0];
    assign b_ar_valid_o = valid_in[1] & has_space[1];
    assign a_r_valid_o  = valid_in[2] & has_space[2];
    assign b_r_valid_o  = valid_in[3] & has_space[3];

    assign a_ar_ready_o = ready_dn[0] & has_space[0];
    assign b_ar_ready_o = ready_dn[1] & has_space[1];
    assign a_r_ready_o  = ready_dn[2] & has_space[2];
    assign b_r_ready_o  = ready_dn[3] & has_space[3];

    assign ar_push_a_o = push[0];
    assign ar_push_b_o = push[1];
    assign r_push_a_o  = push[2];
    assign r_push_b_o  = push[3];

endmodule

//--- src/id_lane.sv
`timescale 1ns/1ps

module id_lane
    import axi_cmp_pkg::*;
#(
    parameter int unsigned FifoDepth = 4
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  ar_beat_t ar_a_i,
    input  ar_beat_t ar_b_i,
    input  r_beat_t  r_a_i,
    input  r_beat_t  r_b_i,
    input  logic     ar_push_a_i,
    input  logic     ar_push_b_i,
    input  logic     r_push_a_i,
    input  logic     r_push_b_i,
    output logic     ar_space_a_o,
    output logic     ar_space_b_o,
    output logic     r_space_a_o,
    output logic     r_space_b_o,
    output logic     ar_mismatch_o,
    output logic     r_mismatch_o,
    output logic     busy_o
);

    ar_beat_t ar_head_a;
    ar_beat_t ar_head_b;
    r_beat_t  r_head_a;
    r_beat_t  r_head_b;
    logic     ar_valid_a;
    logic     ar_valid_b;
    logic     r_valid_a;
    logic     r_valid_b;
    logic     ar_full_a;
    logic     ar_full_b;
    logic     r_full_a;
    logic     r_full_b;
    logic     ar_pair;
    logic     r_pair;

    // ------------------------------
    // Per-bus queues
    // ------------------------------
    beat_fifo #(
        .Depth  ( FifoDepth ),
        .beat_t ( ar_beat_t )
    ) i_fifo_ar_a (
        .clk_i,
        .rst_i,
        .push_i  ( ar_push_a_i ),
        .data_i  ( ar_a_i      ),
        .full_o  ( ar_full_a   ),
        .pop_i   ( ar_pair     ),
        .data_o  ( ar_head_a   ),
        .valid_o ( ar_valid_a  )
    );

    beat_fifo #(
        .Depth  ( FifoDepth ),
        .beat_t ( ar_beat_t )
    ) i_fifo_ar_b (
        .clk_i,
        .rst_i,
        .push_i  ( ar_push_b_i ),
        .data_i  ( ar_b_i      ),
        .full_o  ( ar_full_b   ),
        .pop_i   ( ar_pair     ),
        .data_o  ( ar_head_b   ),
        .valid_o ( ar_valid_b  )
    );

    beat_fifo #(
        .Depth  ( FifoDepth ),
        .beat_t ( r_beat_t  )
    ) i_fifo_r_a (
        .clk_i,
        .rst_i,
        .push_i  ( r_push_a_i ),
        .data_i  ( r_a_i      ),
        .full_o  ( r_full_a   ),
        .pop_i   ( r_pair     ),
        .data_o  ( r_head_a   ),
        .valid_o ( r_valid_a  )
    );

    beat_fifo #(
        .Depth  ( FifoDepth ),
        .beat_t ( r_beat_t  )
    ) i_fifo_r_b (
        .clk_i,
        .rst_i,
        .push_i  ( r_push_b_i ),
        .data_i  ( r_b_i      ),
        .full_o  ( r_full_b   ),
        .pop_i   ( r_pair     ),
        .data_o  ( r_head_b   ),
        .valid_o ( r_valid_b  )
    );

    assign ar_space_a_o = ~ar_full_a;
    assign ar_space_b_o = ~ar_full_b;
    assign r_space_a_o  = ~r_full_a;
    assign r_space_b_o  = ~r_full_b;

    // ------------------------------
    // Head pairing
    // ------------------------------

    // Both heads leave together once the pair is complete
    assign ar_pair = ar_valid_a & ar_valid_b;
    assign r_pair  = r_valid_a & r_valid_b;

    // Whole beat compared, ID included
    assign ar_mismatch_o = ar_pair & (ar_head_a != ar_head_b);
    assign r_mismatch_o  = r_pair & (r_head_a != r_head_b);

    assign busy_o = ar_valid_a | ar_valid_b | r_valid_a | r_valid_b;

endmodule

//--- src/mismatch_collect.sv
`timescale 1ns/1ps

module mismatch_collect
    import axi_cmp_pkg::*;
#(
    parameter int unsigned IdWidth = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic [2**IdWidth-1:0] ar_mismatch_i,
    input  logic [2**IdWidth-1:0] r_mismatch_i,
    input  logic [2**IdWidth-1:0] busy_i,
    output logic [2**IdWidth-1:0] ar_mismatch_o,
    output logic [2**IdWidth-1:0] r_mismatch_o,
    output logic                  mismatch_o,
    output logic                  mismatch_seen_o,
    output count_t                mismatch_count_o,
    output logic                  busy_o
);

    localparam int unsigned NumLanes = 2**IdWidth;
    localparam int unsigned HitW     = $clog2(2 * NumLanes + 1);
    localparam int unsigned SumW     = $bits(count_t) + 1;

    logic [HitW-1:0] hits;
    logic [SumW-1:0] count_sum;
    logic            seen_q;
    count_t          count_q;

    assign ar_mismatch_o = ar_mismatch_i;
    assign r_mismatch_o  = r_mismatch_i;
    assign mismatch_o    = (|ar_mismatch_i) | (|r_mismatch_i);
    assign busy_o        = |busy_i;

    // Number of lane comparisons that failed this cycle
    always_comb begin
        hits = '0;
        for (int i = 0; i < NumLanes; i++) begin
            hits = hits + HitW'(ar_mismatch_i[i]) + HitW'(r_mismatch_i[i]);
        end
    end

    // One spare bit catches the overflow
    assign count_sum = {1'b0, count_q} + SumW'(hits);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            seen_q  <= 1'b0;
            count_q <= '0;
        end else begin
            seen_q <= seen_q | mismatch_o;
            if (count_sum[SumW-1]) begin
                count_q <= '1;
            end else begin
                count_q <= count_sum[SumW-2:0];
            end
        end
    end

    assign mismatch_seen_o  = seen_q;
    assign mismatch_count_o = count_q;

endmodule

//--- src/axi_bus_compare.sv
`timescale 1ns/1ps

module axi_bus_compare
    import axi_cmp_pkg::*;
#(
    parameter int unsigned IdWidth   = 2,
    parameter int unsigned FifoDepth = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    // Bus A
    input  ar_beat_t              a_ar_i,
    input  logic                  a_ar_valid_i,
    output logic                  a_ar_ready_o,
    output ar_beat_t              a_ar_o,
    output logic                  a_ar_valid_o,
    input  logic                  a_ar_ready_i,
    input  r_beat_t               a_r_i,
    input  logic                  a_r_valid_i,
    output logic                  a_r_ready_o,
    output r_beat_t               a_r_o,
    output logic                  a_r_valid_o,
    input  logic                  a_r_ready_i,
    // Bus B
    input  ar_beat_t              b_ar_i,
    input  logic                  b_ar_valid_i,
    output logic                  b_ar_ready_o,
    output ar_beat_t              b_ar_o,
    output logic                  b_ar_valid_o,
    input  logic                  b_ar_ready_i,
    input  r_beat_t               b_r_i,
    input  logic                  b_r_valid_i,
    output logic                  b_r_ready_o,
    output r_beat_t               b_r_o,
    output logic                  b_r_valid_o,
    input  logic                  b_r_ready_i,
    // Results
    output logic [2**IdWidth-1:0] ar_mismatch_o,
    output logic [2**IdWidth-1:0] r_mismatch_o,
    output logic                  mismatch_o,
    output logic                  mismatch_seen_o,
    output count_t                mismatch_count_o,
    output logic                  busy_o
);

    localparam int unsigned NumLanes = 2**IdWidth;

    logic [NumLanes-1:0] ar_push_a;
    logic [NumLanes-1:0] ar_push_b;
    logic [NumLanes-1:0] r_push_a;
    logic [NumLanes-1:0] r_push_b;
    logic [NumLanes-1:0] ar_space_a;
    logic [NumLanes-1:0] ar_space_b;
    logic [NumLanes-1:0] r_space_a;
    logic [NumLanes-1:0] r_space_b;
    logic [NumLanes-1:0] lane_ar_mismatch;
    logic [NumLanes-1:0] lane_r_mismatch;
    logic [NumLanes-1:0] lane_busy;

    // Payloads pass straight through
    assign a_ar_o = a_ar_i;
    assign a_r_o  = a_r_i;
    assign b_ar_o = b_ar_i;
    assign b_r_o  = b_r_i;

    dual_bus_tap #(
        .IdWidth ( IdWidth )
    ) i_tap (
        .a_ar_i, .a_ar_valid_i, .a_ar_ready_o, .a_ar_valid_o, .a_ar_ready_i,
        .a_r_i, .a_r_valid_i, .a_r_ready_o, .a_r_valid_o, .a_r_ready_i,
        .b_ar_i, .b_ar_valid_i, .b_ar_ready_o, .b_ar_valid_o, .b_ar_ready_i,
        .b_r_i, .b_r_valid_i, .b_r_ready_o, .b_r_valid_o, .b_r_ready_i,
        .ar_space_a_i ( ar_space_a ),
        .ar_space_b_i ( ar_space_b ),
        .r_space_a_i  ( r_space_a  ),
        .r_space_b_i  ( r_space_b  ),
        .ar_push_a_o  ( ar_push_a  ),
        .ar_push_b_o  ( ar_push_b  ),
        .r_push_a_o   ( r_push_a   ),
        .r_push_b_o   ( r_push_b   )
    );

    // ------------------------------
    // One lane per decoded ID
    // ------------------------------
    for (genvar l = 0; l < NumLanes; l++) begin : gen_lane
        id_lane #(
            .FifoDepth ( FifoDepth )
        ) i_lane (
            .clk_i,
            .rst_i,
            .ar_a_i        ( a_ar_i              ),
            .ar_b_i        ( b_ar_i              ),
            .r_a_i         ( a_r_i               ),
            .r_b_i         ( b_r_i               ),
            .ar_push_a_i   ( ar_push_a[l]        ),
            .ar_push_b_i   ( ar_push_b[l]        ),
            .r_push_a_i    ( r_push_a[l]         ),
            .r_push_b_i    ( r_push_b[l]         ),
            .ar_space_a_o  ( ar_space_a[l]       ),
            .ar_space_b_o  ( ar_space_b[l]       ),
            .r_space_a_o   ( r_space_a[l]        ),
            .r_space_b_o   ( r_space_b[l]        ),
            .ar_mismatch_o ( lane_ar_mismatch[l] ),
            .r_mismatch_o  ( lane_r_mismatch[l]  ),
            .busy_o        ( lane_busy[l]        )
        );
    end

    mismatch_collect #(
        .IdWidth ( IdWidth )
    ) i_collect (
        .clk_i,
        .rst_i,
        .ar_mismatch_i ( lane_ar_mismatch ),
        .r_mismatch_i  ( lane_r_mismatch  ),
        .busy_i        ( lane_busy        ),
        .ar_mismatch_o,
        .r_mismatch_o,
        .mismatch_o,
        .mismatch_seen_o,
        .mismatch_count_o,
        .busy_o
    );

endmodule

//--- bench/axi_bus_compare_sva.sv
`timescale 1ns/1ps

module axi_bus_compare_sva (
    input logic clk_i,
    input logic rst_i,
    input logic a_ar_valid_i,
    input logic a_ar_valid_o,
    input logic a_r_valid_i,
    input logic a_r_valid_o,
    input logic b_ar_valid_i,
    input logic b_ar_valid_o,
    input logic b_r_valid_i,
    input logic b_r_valid_o,
    input logic mismatch_seen_o
);

    // Number of assertion failures so far
    int error_count = 0;

    // A beat only leaves when one arrives
    a_ar_valid_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        a_ar_valid_o |-> a_ar_valid_i)
        else begin
            error_count++;
            $error("a_ar_valid_o without a_ar_valid_i");
        end
    a_r_valid_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        a_r_valid_o |-> a_r_valid_i)
        else begin
            error_count++;
            $error("a_r_valid_o without a_r_valid_i");
        end
    b_ar_valid_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        b_ar_valid_o |-> b_ar_valid_i)
        else begin
            error_count++;
            $error("b_ar_valid_o without b_ar_valid_i");
        end
    b_r_valid_chk: assert property (@(posedge clk_i) disable iff (rst_i)
        b_r_valid_o |-> b_r_valid_i)
        else begin
            error_count++;
            $error("b_r_valid_o without b_r_valid_i");
        end

    // Sticky flag clears only through reset
    seen_sticky_chk: assert property (@(posedge clk_i)
        $past(mismatch_seen_o) && !$past(rst_i) |-> mismatch_seen_o)
        else begin
            error_count++;
            $error("mismatch_seen_o fell without a reset");
        end

endmodule

bind axi_bus_compare axi_bus_compare_sva i_sva (.*);

//--- bench/tb_axi_bus_compare.sv
`timescale 1ns/1ps

module tb_axi_bus_compare
    import axi_cmp_pkg::*;
();

    localparam int unsigned IdWidth     = 2;
    localparam int unsigned FifoDepth   = 4;
    localparam int          SendTimeout = 500;
    localparam int          IdleTimeout = 500;

    logic     clk_i;
    logic     rst_i;
    ar_beat_t a_ar_i;
    ar_beat_t a_ar_o;
    ar_beat_t b_ar_i;
    ar_beat_t b_ar_o;
    r_beat_t  a_r_i;
    r_beat_t  a_r_o;
    r_beat_t  b_r_i;
    r_beat_t  b_r_o;
    logic     a_ar_valid_i;
    logic     a_ar_ready_o;
    logic     a_ar_valid_o;
    logic     a_ar_ready_i;
    logic     a_r_valid_i;
    logic     a_r_ready_o;
    logic     a_r_valid_o;
    logic     a_r_ready_i;
    logic     b_ar_valid_i;
    logic     b_ar_ready_o;
    logic     b_ar_valid_o;
    logic     b_ar_ready_i;
    logic     b_r_valid_i;
    logic     b_r_ready_o;
    logic     b_r_valid_o;
    logic     b_r_ready_i;
    logic [2**IdWidth-1:0] ar_mismatch_o;
    logic [2**IdWidth-1:0] r_mismatch_o;
    logic     mismatch_o;
    logic     mismatch_seen_o;
    count_t   mismatch_count_o;
    logic     busy_o;

    // Channel index 0 is A AR, 1 is B AR, 2 is A R, 3 is B R
    logic [43:0] sent_q [4][$];
    logic [43:0] g_a [$];
    logic [43:0] g_b [$];
    logic        g_is_r [$];
    int          g_flag [$];
    logic [43:0] order_a [$];
    logic [43:0] order_b [$];
    logic [43:0] part5 [$];
    logic [31:0] rng_state;
    int          exp_count;
    // Lane mismatch pulses seen and expected
    int          ar_hits [2**IdWidth];
    int          r_hits [2**IdWidth];
    int          exp_ar_hits [2**IdWidth];
    int          exp_r_hits [2**IdWidth];

    axi_bus_compare #(
        .IdWidth   ( IdWidth   ),
        .FifoDepth ( FifoDepth )
    ) DUT (.*);

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic check_lane_hits(input string name);
        for (int l = 0; l < 2**IdWidth; l++) begin
            check_equal($sformatf("%s AR mismatches lane %0d", name, l),
                        exp_ar_hits[l], ar_hits[l]);
            check_equal($sformatf("%s R mismatches lane %0d", name, l),
                        exp_r_hits[l], r_hits[l]);
        end
    endtask

    task automatic drive_channel(input int c, input logic [43:0] payload, input logic valid);
        case (c)
            0: begin
                a_ar_i       = payload;
                a_ar_valid_i = valid;
            end
            1: begin
                b_ar_i       = payload;
                b_ar_valid_i = valid;
            end
            2: begin
                a_r_i       = payload[38:0];
                a_r_valid_i = valid;
            end
            default: begin
                b_r_i       = payload[38:0];
                b_r_valid_i = valid;
            end
        endcase
    endtask

    function automatic logic accepted(input int c);
        case (c)
            0:       return a_ar_valid_i & a_ar_ready_o;
            1:       return b_ar_valid_i & b_ar_ready_o;
            2:       return a_r_valid_i & a_r_ready_o;
            default: return b_r_valid_i & b_r_ready_o;
        endcase
    endfunction

    // Starts and ends on a falling edge
    task automatic send_beat(input int c, input logic [43:0] payload);
        int waited;
        waited = 0;
        drive_channel(c, payload, 1'b1);
        sent_q[c].push_back(payload);
        @(posedge clk_i);
        while (!accepted(c)) begin
            waited++;
            if (waited > SendTimeout) begin
                abort_run($sformatf("beat on channel %0d was never accepted", c));
            end
            @(posedge clk_i);
        end
        @(negedge clk_i);
        drive_channel(c, payload, 1'b0);
    endtask

    task automatic wait_idle(input string name);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (busy_o) begin
            waited++;
            if (waited > IdleTimeout) begin
                abort_run($sformatf("%s: busy_o never fell", name));
            end
            @(negedge clk_i);
        end
    endtask

    task automatic match_downstream(input int c, input logic [43:0] got);
        logic [43:0] exp;
        if (sent_q[c].size() == 0) begin
            abort_run($sformatf("beat seen downstream on channel %0d with none sent", c));
        end
        exp = sent_q[c].pop_front();
        check_equal($sformatf("pass-through channel %0d", c), exp, got);
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        int          flag;
        string       line;
        string       tag;
        logic [31:0] f [8];
        ar_beat_t    ar_a;
        ar_beat_t    ar_b;
        r_beat_t     r_a;
        r_beat_t     r_b;
        fd = $fopen("bench/compare_golden.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/compare_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            void'($sscanf(line, "%s", tag));
            if (tag == "AR") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %d",
                            tag, f[0], f[1], f[2], f[3], f[4], f[5], flag);
                if (n != 8) begin
                    abort_run({"malformed AR line in golden file: ", line});
                end
                ar_a = {id_t'(f[0]), addr_t'(f[1]), len_t'(f[2])};
                ar_b = {id_t'(f[3]), addr_t'(f[4]), len_t'(f[5])};
                g_a.push_back(ar_a);
                g_b.push_back(ar_b);
                g_is_r.push_back(1'b0);
            end else begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d", tag,
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], flag);
                if (n != 10) begin
                    abort_run({"malformed R line in golden file: ", line});
                end
                r_a = {id_t'(f[0]), data_t'(f[1]), resp_t'(f[2]), f[3][0]};
                r_b = {id_t'(f[4]), data_t'(f[5]), resp_t'(f[6]), f[7][0]};
                g_a.push_back({5'b0, r_a});
                g_b.push_back({5'b0, r_b});
                g_is_r.push_back(1'b1);
            end
            g_flag.push_back(flag);
        end
        $fclose(fd);
        if (g_a.size() == 0) begin
            abort_run("golden file holds no beat pairs");
        end
    endtask

    // ------------------------------
    // Back-pressure and monitor
    // ------------------------------

    // Ready drops in roughly one cycle out of four
    always @(negedge clk_i) begin
        rng_state    = lcg_next(rng_state);
        a_ar_ready_i = |rng_state[25:24];
        b_ar_ready_i = |rng_state[27:26];
        a_r_ready_i  = |rng_state[29:28];
        b_r_ready_i  = |rng_state[31:30];
    end

    always @(negedge clk_i) begin
        if (DUT.i_sva.error_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end
    end

    always @(posedge clk_i) begin
        if (!rst_i) begin
            if (a_ar_valid_o && a_ar_ready_i) match_downstream(0, a_ar_o);
            if (b_ar_valid_o && b_ar_ready_i) match_downstream(1, b_ar_o);
            if (a_r_valid_o && a_r_ready_i) match_downstream(2, {5'b0, a_r_o});
            if (b_r_valid_o && b_r_ready_i) match_downstream(3, {5'b0, b_r_o});
            for (int l = 0; l < 2**IdWidth; l++) begin
                ar_hits[l] += ar_mismatch_o[l];
                r_hits[l]  += r_mismatch_o[l];
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        ar_beat_t beat;
        r_beat_t  rbeat;
        clk_i     = 1'b0;
        rst_i     = 1'b1;
        rng_state = 32'd18;
        exp_count = 0;
        for (int c = 0; c < 4; c++) begin
            drive_channel(c, '0, 1'b0);
        end
        a_ar_ready_i = 1'b1;
        b_ar_ready_i = 1'b1;
        a_r_ready_i  = 1'b1;
        b_r_ready_i  = 1'b1;
        load_golden();

        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_equal("reset valid outs", 0,
                    {a_ar_valid_o, b_ar_valid_o, a_r_valid_o, b_r_valid_o});
        check_equal("reset busy", 0, busy_o);
        check_equal("reset mismatch", 0, mismatch_o);
        check_equal("reset lane mismatches", 0, {ar_mismatch_o, r_mismatch_o});
        check_equal("reset mismatch seen", 0, mismatch_seen_o);
        check_equal("reset mismatch count", 0, mismatch_count_o);

        // Expected totals and lane pulses from the golden flags
        foreach (g_flag[i]) begin
            exp_count += g_flag[i];
            if (g_flag[i] != 0) begin
                if (g_is_r[i]) begin
                    rbeat = g_a[i][38:0];
                    exp_r_hits[rbeat.id[IdWidth-1:0]] += g_flag[i];
                end else begin
                    beat = g_a[i];
                    exp_ar_hits[beat.id[IdWidth-1:0]] += g_flag[i];
                end
            end
        end

        // Golden pairs sent on both buses in file order
        fork
            foreach (g_a[i]) send_beat(g_is_r[i] ? 2 : 0, g_a[i]);
            foreach (g_b[i]) send_beat(g_is_r[i] ? 3 : 1, g_b[i]);
        join
        wait_idle("golden pairs");
        check_equal("golden mismatch count", exp_count, mismatch_count_o);
        check_equal("golden mismatch seen", exp_count != 0, mismatch_seen_o);
        check_lane_hits("golden");

        // B groups the matching AR beats by lane and keeps the order within an ID
        foreach (g_a[i]) begin
            if (!g_is_r[i] && g_flag[i] == 0) order_a.push_back(g_a[i]);
        end
        for (int lane = 0; lane < 2**IdWidth; lane++) begin
            foreach (order_a[i]) begin
                beat = order_a[i];
                if (beat.id[IdWidth-1:0] == lane) order_b.push_back(order_a[i]);
            end
        end
        fork
            foreach (order_a[i]) send_beat(0, order_a[i]);
            foreach (order_b[i]) send_beat(1, order_b[i]);
        join
        wait_idle("interleaved IDs");
        check_equal("interleaved IDs count", exp_count, mismatch_count_o);
        check_lane_hits("interleaved IDs");

        // Five ID 1 beats overfill lane 1 on bus A
        for (int k = 0; k < 5; k++) begin
            beat = {id_t'(1), addr_t'(32'h5000_0000 + k * 64), len_t'(k)};
            part5.push_back(beat);
        end
        for (int k = 0; k < 4; k++) send_beat(0, part5[k]);
        check_equal("full lane busy", 1, busy_o);
        fork
            send_beat(0, part5[4]);
            begin
                repeat (10) begin
                    @(posedge clk_i);
                    check_equal("full lane ready", 0, a_ar_ready_o);
                    check_equal("full lane valid", 0, a_ar_valid_o);
                end
                @(negedge clk_i);
                foreach (part5[k]) send_beat(1, part5[k]);
            end
        join
        wait_idle("full lane");
        check_equal("full lane count", exp_count, mismatch_count_o);
        check_lane_hits("full lane");

        check_equal("beats left undelivered", 0,
                    sent_q[0].size() + sent_q[1].size() + sent_q[2].size() + sent_q[3].size());
        $display("All tests passed");
        $finish;
    end

endmodule

//--- bench/compare_golden.txt
# AR columns: tag a_id a_addr a_len b_id b_addr b_len mismatch
# R columns:  tag a_id a_data a_resp a_last b_id b_data b_resp b_last mismatch
AR 0 10000000 03 0 10000000 03 0
R 0 deadbeef 0 1 0 deadbeef 0 1 0
AR 1 10000040 01 1 10000040 01 0
AR 2 20000000 07 2 20000000 07 0
R 1 12345678 0 0 1 12345678 0 0 0
AR 3 3000a000 00 3 3000a000 00 0
R 1 9abcdef0 0 1 1 9abcdef0 0 1 0
AR 1 100000c0 03 1 100000c4 03 1
R 2 00000001 0 1 2 00000001 2 1 1
AR 1 10000080 0f 1 10000080 0f 0
AR 0 10000100 01 0 10000100 01 0
R 3 cafef00d 0 0 3 cafef00d 0 1 1
AR 2 20000800 07 2 20000800 06 1
AR 3 3000b000 02 3 3000b000 02 0
R 3 0badc0de 0 1 3 0badc0de 0 1 0
AR 0 40000000 00 4 40000000 00 1
R 0 55aa55aa 0 1 0 55aa55ab 0 1 1
AR 2 20000400 03 2 20000400 03 0
R 2 a5a5a5a5 3 1 2 a5a5a5a5 3 1 0

//--- all.f
src/axi_cmp_pkg.sv
src/beat_fifo.sv
src/dual_bus_tap.sv
src/id_lane.sv
src/mismatch_collect.sv
src/axi_bus_compare.sv
bench/axi_bus_compare_sva.sv
bench/tb_axi_bus_compare.sv
